/* flist.f */
hw/core_pkg.sv
hw/lsu_pkg.sv
hw/lsu_store_align.sv
hw/lsu_load_extract.sv
hw/lsu.sv
hw/data_ram.sv
hw/lsu_subsys.sv
test/lsu_sva.sv
test/tb_lsu_subsys.sv

/* Bender.yml */
package:
  name: lsu_subsys

sources:
  - hw/core_pkg.sv
  - hw/lsu_pkg.sv
  - hw/lsu_store_align.sv
  - hw/lsu_load_extract.sv
  - hw/lsu.sv
  - hw/data_ram.sv
  - hw/lsu_subsys.sv
  - target: test
    files:
      - test/lsu_sva.sv
      - test/tb_lsu_subsys.sv

/* test/tb_lsu_subsys.sv */
/*
  Directed testbench for the data memory subsystem.
  The whole RAM is filled through the DUT first, so every later load is defined.
  Expected results come from a reference word memory updated in request order.
*/
`timescale 1ns/1ns

module tb_lsu_subsys;

  localparam int RESET_CYCLES = 10;
  localparam int unsigned SEED = 32'h1542_0247;

  // Requests issued by each test
  localparam int N_FILL  = lsu_pkg::DMEM_WORDS;
  localparam int N_ROUND = 16;
  localparam int N_LANE  = 18;
  localparam int N_EXT   = 26;
  localparam int N_MIS   = 12;
  localparam int N_PIPE  = 17;
  localparam int N_RAND  = 200;
  localparam int N_REQ   = N_FILL + N_ROUND + N_LANE + N_EXT + N_MIS + N_PIPE + N_RAND;
  // Each of the seven drains waits out the load latency plus a few idle cycles
  localparam int MAX_CYCLES = RESET_CYCLES + N_REQ + 7 * (lsu_pkg::LOAD_LATENCY + 4) + 100;

  logic               clk_i = 1'b0;
  logic               rstn_i;
  logic               req_valid_i;
  lsu_pkg::lsu_op_e   req_op_i;
  core_pkg::addr_t    req_addr_i;
  core_pkg::data_t    req_wdata_i;
  core_pkg::reg_idx_t req_rd_i;
  logic               wb_valid_o;
  core_pkg::data_t    wb_data_o;
  core_pkg::reg_idx_t wb_rd_o;
  logic               misaligned_load_o;
  logic               misaligned_store_o;
  core_pkg::addr_t    misaligned_addr_o;

  int          cyc    = 0;                           // Posedge count
  int          errors = 0;
  int          checks = 0;
  int unsigned seed_val;
  logic        mis_due_now;
  logic        exp_mis_ld;
  logic        exp_mis_st;

  core_pkg::data_t ref_mem [lsu_pkg::DMEM_WORDS];    // Reference word memory

  // Pending writebacks in issue order
  core_pkg::data_t    wb_exp_data [$];
  core_pkg::reg_idx_t wb_exp_rd   [$];
  int                 wb_exp_due  [$];
  // Pending misaligned flags
  logic               mis_exp_store [$];
  core_pkg::addr_t    mis_exp_addr  [$];
  int                 mis_exp_due   [$];

  lsu_pkg::lsu_op_e op_list [8] = '{lsu_pkg::LSU_LB, lsu_pkg::LSU_LH, lsu_pkg::LSU_LW,
                                    lsu_pkg::LSU_LBU, lsu_pkg::LSU_LHU, lsu_pkg::LSU_SB,
                                    lsu_pkg::LSU_SH, lsu_pkg::LSU_SW};

  lsu_subsys uut (.*);

  always #20 clk_i = ~clk_i;                         // 40 ns period

  ////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////
  function automatic int access_bytes(lsu_pkg::lsu_op_e op);
    case (op)
      lsu_pkg::LSU_LB, lsu_pkg::LSU_LBU, lsu_pkg::LSU_SB: return 1;
      lsu_pkg::LSU_LH, lsu_pkg::LSU_LHU, lsu_pkg::LSU_SH: return 2;
      default:                                            return 4;
    endcase
  endfunction

  function automatic logic is_store_op(lsu_pkg::lsu_op_e op);
    return op inside {lsu_pkg::LSU_SB, lsu_pkg::LSU_SH, lsu_pkg::LSU_SW};
  endfunction

  function automatic logic addr_misaligned(lsu_pkg::lsu_op_e op, core_pkg::addr_t addr);
    return (int'(addr[1:0]) % access_bytes(op)) != 0; // Offset must be a multiple of size
  endfunction

  function automatic int word_index(core_pkg::addr_t addr);
    return int'((addr >> 2) % lsu_pkg::DMEM_WORDS);   // Wraps modulo RAM depth
  endfunction

  function automatic core_pkg::data_t fill_word(core_pkg::addr_t addr);
    return (addr * 32'h9E37_79B1) ^ {addr[15:0], ~addr[15:0]};
  endfunction

  // Copy the low bytes of wdata onto the lanes starting at the offset
  function automatic core_pkg::data_t merge_store(core_pkg::data_t old,
      lsu_pkg::lsu_op_e op, core_pkg::addr_t addr, core_pkg::data_t wdata);
    core_pkg::data_t word;
    int              lane;
    word = old;
    lane = int'(addr[1:0]);
    for (int b = 0; b < access_bytes(op); b++) begin
      word[8*(lane+b) +: 8] = wdata[8*b +: 8];
    end
    return word;
  endfunction

  function automatic core_pkg::data_t expected_load(core_pkg::data_t word,
      lsu_pkg::lsu_op_e op, core_pkg::addr_t addr);
    core_pkg::data_t val;
    core_pkg::data_t mask;
    int              nbits;
    nbits = 8 * access_bytes(op);
    mask  = (32'h1 << nbits) - 1;                    // All ones for a word
    val   = (word >> (8 * int'(addr[1:0]))) & mask;
    if (!(op inside {lsu_pkg::LSU_LBU, lsu_pkg::LSU_LHU}) && val[nbits-1]) begin
      val = val | ~mask;                             // Sign extension
    end
    return val;
  endfunction

  task automatic log_error(string msg);
    errors++;
    $display("%s (at %0t)", msg, $time);
  endtask

  ////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////
  task automatic drive_req(lsu_pkg::lsu_op_e op, core_pkg::addr_t addr,
      core_pkg::data_t wdata, core_pkg::reg_idx_t rd);
    int idx;
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_op_i    = op;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_rd_i    = rd;
    idx = word_index(addr);
    if (addr_misaligned(op, addr)) begin
      mis_exp_store.push_back(is_store_op(op));      // Flag one edge later
      mis_exp_addr.push_back(addr);
      mis_exp_due.push_back(cyc + 1);
    end else if (is_store_op(op)) begin
      ref_mem[idx] = merge_store(ref_mem[idx], op, addr, wdata);
    end else begin
      wb_exp_data.push_back(expected_load(ref_mem[idx], op, addr));
      wb_exp_rd.push_back(rd);
      wb_exp_due.push_back(cyc + lsu_pkg::LOAD_LATENCY);
    end
  endtask

  task automatic idle_cycle();
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  // Wait until every expected response has been seen
  task automatic drain_pipeline();
    idle_cycle();
    while (wb_exp_due.size() > 0 || mis_exp_due.size() > 0) begin
      idle_cycle();
    end
    idle_cycle();
  endtask

  task automatic fill_memory();
    for (int i = 0; i < N_FILL; i++) begin
      drive_req(lsu_pkg::LSU_SW, core_pkg::addr_t'(i * 4), fill_word(i * 4), '0);
    end
    drain_pipeline();
  endtask

  task automatic word_round_trip();
    core_pkg::addr_t addrs [8];
    for (int i = 0; i < 8; i++) begin
      addrs[i] = $urandom() & 32'hFFFF_FFFC;          // High bits exercise the wrap
      drive_req(lsu_pkg::LSU_SW, addrs[i], $urandom(), '0);
    end
    for (int i = 0; i < 8; i++) begin
      drive_req(lsu_pkg::LSU_LW, addrs[i], '0, core_pkg::reg_idx_t'($urandom_range(1, 31)));
    end
    drain_pipeline();
  endtask

  task automatic lane_merging();
    core_pkg::addr_t base;
    base = 32'h0000_0100;
    for (int off = 0; off < 4; off++) begin
      drive_req(lsu_pkg::LSU_SW, base, $urandom(), '0);
      drive_req(lsu_pkg::LSU_SB, base + off, $urandom(), '0);
      drive_req(lsu_pkg::LSU_LW, base, '0, core_pkg::reg_idx_t'(off + 1));
    end
    for (int off = 0; off < 4; off += 2) begin
      drive_req(lsu_pkg::LSU_SW, base, $urandom(), '0);
      drive_req(lsu_pkg::LSU_SH, base + off, $urandom(), '0);
      drive_req(lsu_pkg::LSU_LW, base, '0, core_pkg::reg_idx_t'(off + 8));
    end
    drain_pipeline();
  endtask

  task automatic load_extension();
    core_pkg::data_t words [2];
    core_pkg::addr_t base;
    words[0] = 32'h80FF_7F81;                        // Mixed sign bits per byte and half
    words[1] = 32'h7F01_8C70;
    for (int w = 0; w < 2; w++) begin
      base = 32'h0000_0200 + 4 * w;
      drive_req(lsu_pkg::LSU_SW, base, words[w], '0);
      for (int off = 0; off < 4; off++) begin
        drive_req(lsu_pkg::LSU_LB, base + off, '0, core_pkg::reg_idx_t'(off + 1));
        drive_req(lsu_pkg::LSU_LBU, base + off, '0, core_pkg::reg_idx_t'(off + 5));
      end
      for (int off = 0; off < 4; off += 2) begin
        drive_req(lsu_pkg::LSU_LH, base + off, '0, core_pkg::reg_idx_t'(off + 10));
        drive_req(lsu_pkg::LSU_LHU, base + off, '0, core_pkg::reg_idx_t'(off + 20));
      end
    end
    drain_pipeline();
  endtask

  task automatic misaligned_access();
    core_pkg::addr_t base;
    base = 32'h0000_0300;
    drive_req(lsu_pkg::LSU_SW, base, 32'hCAFE_F00D, '0);
    drive_req(lsu_pkg::LSU_LH, base + 1, '0, 5'd1);
    drive_req(lsu_pkg::LSU_LHU, base + 3, '0, 5'd2);
    drive_req(lsu_pkg::LSU_LW, base + 1, '0, 5'd3);
    drive_req(lsu_pkg::LSU_LW, base + 2, '0, 5'd4);
    drive_req(lsu_pkg::LSU_LW, base + 3, '0, 5'd5);
    drive_req(lsu_pkg::LSU_SH, base + 1, 32'h1111_1111, '0);
    drive_req(lsu_pkg::LSU_SH, base + 3, 32'h2222_2222, '0);
    drive_req(lsu_pkg::LSU_SW, base + 1, 32'h3333_3333, '0);
    drive_req(lsu_pkg::LSU_SW, base + 2, 32'h4444_4444, '0);
    drive_req(lsu_pkg::LSU_SW, base + 3, 32'h5555_5555, '0);
    drive_req(lsu_pkg::LSU_LW, base, '0, 5'd7);       // Word must be untouched
    drain_pipeline();
  endtask

  task automatic back_to_back_loads();
    core_pkg::addr_t base;
    base = 32'h0000_0400;
    for (int i = 0; i < 4; i++) begin
      drive_req(lsu_pkg::LSU_SW, base + 4 * i, $urandom(), '0);
    end
    for (int i = 0; i < 4; i++) begin
      drive_req(lsu_pkg::LSU_LW, base + 4 * i, '0, core_pkg::reg_idx_t'(i + 1));
    end
    // Store followed at once by loads of the same word
    drive_req(lsu_pkg::LSU_SW, base + 8, $urandom(), '0);
    drive_req(lsu_pkg::LSU_LW, base + 8, '0, 5'd9);
    drive_req(lsu_pkg::LSU_LB, base + 9, '0, 5'd10);
    drive_req(lsu_pkg::LSU_SH, base + 14, $urandom(), '0);
    drive_req(lsu_pkg::LSU_LHU, base + 14, '0, 5'd11);
    drive_req(lsu_pkg::LSU_LW, base + 12, '0, 5'd12);
    // Load then store then load on one word
    drive_req(lsu_pkg::LSU_LW, base + 4, '0, 5'd13);
    drive_req(lsu_pkg::LSU_SW, base + 4, $urandom(), '0);
    drive_req(lsu_pkg::LSU_LW, base + 4, '0, 5'd14);
    drain_pipeline();
  endtask

  task automatic random_mix();
    lsu_pkg::lsu_op_e op;
    for (int i = 0; i < N_RAND; i++) begin
      op = op_list[$urandom_range(0, 7)];
      drive_req(op, $urandom(), $urandom(), core_pkg::reg_idx_t'($urandom()));
    end
    drain_pipeline();
  endtask

  ////////////////////////////////////////////////////
  // Response checks at the falling edge
  ////////////////////////////////////////////////////
  always @(negedge clk_i) begin
    if (rstn_i) begin
      if (wb_exp_due.size() > 0 && wb_exp_due[0] == cyc) begin
        checks++;
        assert (wb_valid_o === 1'b1)
          else log_error($sformatf("No writeback for the load due in cycle %0d", cyc));
        assert (wb_data_o === wb_exp_data[0])
          else log_error($sformatf("Mismatch wb_data_o: got %h expected %h",
                                   wb_data_o, wb_exp_data[0]));
        assert (wb_rd_o === wb_exp_rd[0])
          else log_error($sformatf("Mismatch wb_rd_o: got %h expected %h",
                                   wb_rd_o, wb_exp_rd[0]));
        void'(wb_exp_data.pop_front());
        void'(wb_exp_rd.pop_front());
        void'(wb_exp_due.pop_front());
      end else begin
        assert (wb_valid_o === 1'b0)
          else log_error($sformatf("Unexpected writeback in cycle %0d", cyc));
      end
      mis_due_now = mis_exp_due.size() > 0 && mis_exp_due[0] == cyc;
      exp_mis_ld  = mis_due_now && !mis_exp_store[0];
      exp_mis_st  = mis_due_now && mis_exp_store[0];
      assert (misaligned_load_o === exp_mis_ld)
        else log_error($sformatf("Mismatch misaligned_load_o: got %h expected %h",
                                 misaligned_load_o, exp_mis_ld));
      assert (misaligned_store_o === exp_mis_st)
        else log_error($sformatf("Mismatch misaligned_store_o: got %h expected %h",
                                 misaligned_store_o, exp_mis_st));
      if (mis_due_now) begin
        checks++;
        assert (misaligned_addr_o === mis_exp_addr[0])
          else log_error($sformatf("Mismatch misaligned_addr_o: got %h expected %h",
                                   misaligned_addr_o, mis_exp_addr[0]));
        void'(mis_exp_store.pop_front());
        void'(mis_exp_addr.pop_front());
        void'(mis_exp_due.pop_front());
      end
    end
  end

  // Run limit from the request count
  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("Timeout, run stopped after %0d cycles with %0d errors", cyc, errors);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    rstn_i      = 1'b0;
    req_valid_i = 1'b0;
    req_op_i    = lsu_pkg::LSU_LW;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_rd_i    = '0;
    seed_val    = $urandom(SEED);
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rstn_i = 1'b1;
    fill_memory();
    word_round_trip();
    lane_merging();
    load_extension();
    misaligned_access();
    back_to_back_loads();
    random_mix();
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             uut.u_lsu.u_lsu_sva.fail_count);
    if (errors == 0 && uut.u_lsu.u_lsu_sva.fail_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : tb_lsu_subsys

/* test/lsu_sva.sv */
/*
  Concurrent checks bound into every lsu instance.
  Latency check relies on the LSU having no stalls.
*/
`timescale 1ns/1ns

module lsu_sva (
  input logic               clk_i,
  input logic               rstn_i,
  input logic               load_issue_i,          // Valid aligned load at the request
  input logic               wb_valid_i,
  input logic               misaligned_load_i,
  input logic               misaligned_store_i,
  input core_pkg::byte_en_t mem_we_i
);

  int fail_count = 0;                              // Failed assertion count

  ////////////////////////////////////////////////////
  // Reset and exclusivity
  ////////////////////////////////////////////////////
  assert property (@(posedge clk_i) !rstn_i |=>
                   (!wb_valid_i && !misaligned_load_i && !misaligned_store_i && mem_we_i == '0))
    else begin
      fail_count++;
      $error("Outputs not quiet after reset");
    end

  assert property (@(posedge clk_i) disable iff (!rstn_i)
                   !(misaligned_load_i && misaligned_store_i))
    else begin
      fail_count++;
      $error("Both misaligned flags high together");
    end

  // Writeback exactly LOAD_LATENCY edges after each load, and never otherwise
  assert property (@(posedge clk_i) disable iff (!rstn_i)
                   load_issue_i |-> ##(lsu_pkg::LOAD_LATENCY) wb_valid_i)
    else begin
      fail_count++;
      $error("Load writeback missing at the fixed latency");
    end

  assert property (@(posedge clk_i) disable iff (!rstn_i)
                   wb_valid_i |-> $past(load_issue_i, lsu_pkg::LOAD_LATENCY))
    else begin
      fail_count++;
      $error("Writeback without a matching load");
    end

endmodule : lsu_sva

bind lsu lsu_sva u_lsu_sva (
  .clk_i              (clk_i),
  .rstn_i             (rstn_i),
  .load_issue_i       (load_issue),
  .wb_valid_i         (wb_valid_o),
  .misaligned_load_i  (misaligned_load_o),
  .misaligned_store_i (misaligned_store_o),
  .mem_we_i           (mem_we_o)
);

/* hw/lsu_subsys.sv */
/*
  Data memory subsystem: load-store unit and its block RAM.
  Loads return LOAD_LATENCY cycles after the request, writeback cannot stall.
*/
`timescale 1ns/1ns

module lsu_subsys (
  input  logic               clk_i,
  input  logic               rstn_i,

  input  logic               req_valid_i,
  input  lsu_pkg::lsu_op_e   req_op_i,
  input  core_pkg::addr_t    req_addr_i,
  input  core_pkg::data_t    req_wdata_i,
  input  core_pkg::reg_idx_t req_rd_i,

  output logic               wb_valid_o,
  output core_pkg::data_t    wb_data_o,
  output core_pkg::reg_idx_t wb_rd_o,

  output logic               misaligned_load_o,
  output logic               misaligned_store_o,
  output core_pkg::addr_t    misaligned_addr_o
);

  // LSU to RAM
  lsu_pkg::dmem_idx_t mem_idx;
  core_pkg::byte_en_t mem_we;
  core_pkg::data_t    mem_wdata;
  core_pkg::data_t    mem_rdata;

  lsu u_lsu (
    .clk_i              (clk_i),
    .rstn_i             (rstn_i),
    .req_valid_i        (req_valid_i),
    .req_op_i           (req_op_i),
    .req_addr_i         (req_addr_i),
    .req_wdata_i        (req_wdata_i),
    .req_rd_i           (req_rd_i),
    .wb_valid_o         (wb_valid_o),
    .wb_data_o          (wb_data_o),
    .wb_rd_o            (wb_rd_o),
    .misaligned_load_o  (misaligned_load_o),
    .misaligned_store_o (misaligned_store_o),
    .misaligned_addr_o  (misaligned_addr_o),
    .mem_idx_o          (mem_idx),
    .mem_we_o           (mem_we),
    .mem_wdata_o        (mem_wdata),
    .mem_rdata_i        (mem_rdata)
  );

  data_ram u_data_ram (
    .clk_i   (clk_i),
    .idx_i   (mem_idx),
    .we_i    (mem_we),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule : lsu_subsys

/* hw/data_ram.sv */
/*
  Single-port byte-writable data RAM, DMEM_WORDS deep, one-cycle read.
  No-change mode: rdata_o keeps its value in any cycle with a write enable set.
  Contents are undefined after power up.
*/
`timescale 1ns/1ns

module data_ram (
  input  logic               clk_i,
  input  lsu_pkg::dmem_idx_t idx_i,
  input  core_pkg::byte_en_t we_i,
  input  core_pkg::data_t    wdata_i,
  output core_pkg::data_t    rdata_o
);

  core_pkg::data_t mem_q [lsu_pkg::DMEM_WORDS];    // Storage array

  ////////////////////////////////////////////////////
  // Byte lane writes
  ////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < core_pkg::NUM_BE; b++) begin
      if (we_i[b]) begin
        mem_q[idx_i][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  // Registered read, held while writing
  always_ff @(posedge clk_i) begin
    if (we_i == '0) begin
      rdata_o <= mem_q[idx_i];
    end
  end

endmodule : data_ram

/* hw/lsu.sv */
/*
  Load-store unit for a single-port data RAM with one-cycle registered read.
  One request per clock, no back-pressure. Loads write back LOAD_LATENCY
  edges after the request edge. Misaligned accesses never reach the RAM;
  they raise a one-cycle flag and the faulting address is held after it.
*/
`timescale 1ns/1ns

module lsu (
  input  logic                clk_i,
  input  logic                rstn_i,

  // Request from the execute stage
  input  logic                req_valid_i,
  input  lsu_pkg::lsu_op_e    req_op_i,
  input  core_pkg::addr_t     req_addr_i,
  input  core_pkg::data_t     req_wdata_i,
  input  core_pkg::reg_idx_t  req_rd_i,

  // Register file writeback
  output logic                wb_valid_o,
  output core_pkg::data_t     wb_data_o,
  output core_pkg::reg_idx_t  wb_rd_o,

  // Exceptions to the trap logic
  output logic                misaligned_load_o,
  output logic                misaligned_store_o,
  output core_pkg::addr_t     misaligned_addr_o,

  // Data RAM port
  output lsu_pkg::dmem_idx_t  mem_idx_o,
  output core_pkg::byte_en_t  mem_we_o,
  output core_pkg::data_t     mem_wdata_o,
  input  core_pkg::data_t     mem_rdata_i
);

  localparam int unsigned LAST = lsu_pkg::LOAD_STAGES - 1;

  logic                misaligned;                 // Access breaks size alignment
  logic                is_store;
  logic                load_issue;                 // Valid aligned load this cycle
  core_pkg::byte_off_t req_off;
  core_pkg::data_t     st_data;
  core_pkg::byte_en_t  st_be;

  // Load pipeline, index 0 is the request register stage
  logic                pipe_valid_q [lsu_pkg::LOAD_STAGES];
  lsu_pkg::lsu_op_e    pipe_op_q    [lsu_pkg::LOAD_STAGES];
  core_pkg::byte_off_t pipe_off_q   [lsu_pkg::LOAD_STAGES];
  core_pkg::reg_idx_t  pipe_rd_q    [lsu_pkg::LOAD_STAGES];

  // Writeback stage
  core_pkg::data_t     wb_word_q;                  // Raw RAM word
  lsu_pkg::lsu_op_e    wb_op_q;
  core_pkg::byte_off_t wb_off_q;

  assign is_store = req_op_i[lsu_pkg::OP_STORE_BIT];
  assign req_off  = req_addr_i[1:0];

  ////////////////////////////////////////////////////
  // Alignment check
  ////////////////////////////////////////////////////
  always_comb begin
    case (req_op_i)
      lsu_pkg::LSU_LH, lsu_pkg::LSU_LHU, lsu_pkg::LSU_SH: misaligned = req_off[0];
      lsu_pkg::LSU_LW, lsu_pkg::LSU_SW:                   misaligned = |req_off;
      default:                                            misaligned = 1'b0; // Bytes
    endcase
  end

  assign load_issue = req_valid_i & ~is_store & ~misaligned;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      misaligned_load_o  <= 1'b0;
      misaligned_store_o <= 1'b0;
    end else begin
      misaligned_load_o  <= req_valid_i & misaligned & ~is_store; // One cycle pulse
      misaligned_store_o <= req_valid_i & misaligned & is_store;
    end
  end

  // Faulting address stays until the next misaligned access
  always_ff @(posedge clk_i) begin
    if (req_valid_i && misaligned) begin
      misaligned_addr_o <= req_addr_i;
    end
  end

  ////////////////////////////////////////////////////
  // Memory request register
  ////////////////////////////////////////////////////
  lsu_store_align u_store_align (
    .op_i    (req_op_i),
    .off_i   (req_off),
    .wdata_i (req_wdata_i),
    .data_o  (st_data),
    .be_o    (st_be)
  );

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      mem_we_o <= '0;
    end else if (req_valid_i && !misaligned) begin
      mem_we_o <= st_be;                           // Zero for loads
    end else begin
      mem_we_o <= '0;
    end
  end

  always_ff @(posedge clk_i) begin
    mem_idx_o   <= req_addr_i[lsu_pkg::DMEM_IDX_W+1:2]; // Wraps modulo RAM depth
    mem_wdata_o <= st_data;
  end

  ////////////////////////////////////////////////////
  // Load pipeline
  ////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 0; i < lsu_pkg::LOAD_STAGES; i++) begin
        pipe_valid_q[i] <= 1'b0;
      end
    end else begin
      pipe_valid_q[0] <= load_issue;
      for (int i = 1; i < lsu_pkg::LOAD_STAGES; i++) begin
        pipe_valid_q[i] <= pipe_valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    pipe_op_q[0]  <= req_op_i;                     // Sideband follows the valid bit
    pipe_off_q[0] <= req_off;
    pipe_rd_q[0]  <= req_rd_i;
    for (int i = 1; i < lsu_pkg::LOAD_STAGES; i++) begin
      pipe_op_q[i]  <= pipe_op_q[i-1];
      pipe_off_q[i] <= pipe_off_q[i-1];
      pipe_rd_q[i]  <= pipe_rd_q[i-1];
    end
  end

  ////////////////////////////////////////////////////
  // Writeback
  ////////////////////////////////////////////////////
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      wb_valid_o <= 1'b0;
    end else begin
      wb_valid_o <= pipe_valid_q[LAST];
    end
  end

  always_ff @(posedge clk_i) begin
    wb_word_q <= mem_rdata_i;                      // RAM word read on the previous edge
    wb_op_q   <= pipe_op_q[LAST];
    wb_off_q  <= pipe_off_q[LAST];
    wb_rd_o   <= pipe_rd_q[LAST];
  end

  lsu_load_extract u_load_extract (
    .op_i   (wb_op_q),
    .off_i  (wb_off_q),
    .word_i (wb_word_q),
    .data_o (wb_data_o)
  );

endmodule : lsu

/* hw/lsu_load_extract.sv */
/*
  Combinational load result formatting.
  Selects the byte or halfword given by the offset and extends it to XLEN.
  Offset is assumed legal for the access size.
*/
`timescale 1ns/1ns

module lsu_load_extract (
  input  lsu_pkg::lsu_op_e    op_i,
  input  core_pkg::byte_off_t off_i,
  input  core_pkg::data_t     word_i,
  output core_pkg::data_t     data_o
);

  logic [4:0]      bit_shift;
  core_pkg::data_t shifted_word;                   // Addressed byte moved to lane 0
  logic [7:0]      sel_byte;
  logic [15:0]     sel_half;

  assign bit_shift    = {off_i, 3'b000};
  assign shifted_word = word_i >> bit_shift;
  assign sel_byte     = shifted_word[7:0];

  // Halfword picked by offset bit 1 only
  assign sel_half = off_i[1] ? word_i[31:16] : word_i[15:0];

  ////////////////////////////////////////////////////
  // Extension by op
  ////////////////////////////////////////////////////
  always_comb begin
    case (op_i)
      lsu_pkg::LSU_LB: begin
        data_o = {{24{sel_byte[7]}}, sel_byte};    // Sign extend byte
      end
      lsu_pkg::LSU_LBU: begin
        data_o = {24'h000000, sel_byte};           // Zero extend byte
      end
      lsu_pkg::LSU_LH: begin
        data_o = {{16{sel_half[15]}}, sel_half};   // Sign extend half
      end
      lsu_pkg::LSU_LHU: begin
        data_o = {16'h0000, sel_half};             // Zero extend half
      end
      lsu_pkg::LSU_LW: begin
        data_o = word_i;
      end
      default: begin
        data_o = '0;                               // Stores never write back
      end
    endcase
  end

endmodule : lsu_load_extract

/* hw/lsu_store_align.sv */
/*
  Combinational store lane placement.
  Assumes the address offset is already legal for the access size.
  Loads and unknown ops give zero enables and zero data.
*/
`timescale 1ns/1ns

module lsu_store_align (
  input  lsu_pkg::lsu_op_e   op_i,
  input  core_pkg::byte_off_t off_i,
  input  core_pkg::data_t    wdata_i,
  output core_pkg::data_t    data_o,
  output core_pkg::byte_en_t be_o
);

  logic [4:0] bit_shift;                           // Lane offset in bits

  assign bit_shift = {off_i, 3'b000};

  always_comb begin
    data_o = '0;
    be_o   = '0;
    case (op_i)
      lsu_pkg::LSU_SB: begin
        // Byte lands on the addressed lane only
        data_o = core_pkg::data_t'(wdata_i[7:0]) << bit_shift;
        be_o   = core_pkg::byte_en_t'(4'b0001) << off_i;
      end
      lsu_pkg::LSU_SH: begin
        if (off_i[1]) begin                        // Upper half
          data_o = {wdata_i[15:0], 16'h0000};
          be_o   = 4'b1100;
        end else begin                             // Lower half
          data_o = {16'h0000, wdata_i[15:0]};
          be_o   = 4'b0011;
        end
      end
      lsu_pkg::LSU_SW: begin
        data_o = wdata_i;                          // Whole word, all lanes
        be_o   = 4'b1111;
      end
      default: begin
        data_o = '0;                               // Loads write nothing
        be_o   = '0;
      end
    endcase
  end

endmodule : lsu_store_align

/* hw/lsu_pkg.sv */
/*
  LSU operation encoding, data memory geometry and load pipeline depth.
  Op bit 3 marks a store, bits 1:0 give the access size (byte, half, word).
  Bit 2 marks an unsigned load.
*/

package lsu_pkg;

  // Load/store operation, bit 3 = store, bit 2 = unsigned, bits 1:0 = size
  typedef enum logic [3:0] {
    LSU_LB  = 4'b0000,
    LSU_LH  = 4'b0001,
    LSU_LW  = 4'b0010,
    LSU_LBU = 4'b0100,
    LSU_LHU = 4'b0101,
    LSU_SB  = 4'b1000,
    LSU_SH  = 4'b1001,
    LSU_SW  = 4'b1010
  } lsu_op_e;

  localparam int unsigned OP_STORE_BIT = 3;        // Store marker inside lsu_op_e

  ////////////////////////////////////////////////////
  // Data memory geometry
  ////////////////////////////////////////////////////
  localparam int unsigned DMEM_WORDS = 256;        // Depth in 32-bit words
  localparam int unsigned DMEM_IDX_W = $clog2(DMEM_WORDS);

  typedef logic [DMEM_IDX_W-1:0] dmem_idx_t;       // Word index, address wraps

  ////////////////////////////////////////////////////
  // Load timing
  ////////////////////////////////////////////////////
  // Request edge to writeback: request reg, RAM read, word latch
  localparam int unsigned LOAD_LATENCY = 3;
  localparam int unsigned LOAD_STAGES  = LOAD_LATENCY - 1; // Stages before the word latch

endpackage : lsu_pkg

/* hw/core_pkg.sv */
/*
  Core-wide widths for a 32-bit RV32I datapath.
  Only XLEN = 32 is supported; byte lanes assume four 8-bit lanes per word.
*/

package core_pkg;

  localparam int unsigned XLEN     = 32;           // Data and address width
  localparam int unsigned NUM_REGS = 32;           // Integer register file depth
  localparam int unsigned NUM_BE   = XLEN / 8;     // Byte lanes per word

  // Data word as held in registers and memory
  typedef logic [XLEN-1:0] data_t;

  // Byte address, full width before any wrap into the RAM
  typedef logic [XLEN-1:0] addr_t;

  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;  // Register file index
  typedef logic [NUM_BE-1:0]           byte_en_t;  // One enable per byte lane
  typedef logic [$clog2(NUM_BE)-1:0]   byte_off_t; // Byte offset in a word

endpackage : core_pkg
